//--- src/cpu_pkg.sv
package cpu_pkg;

    // ********************
    // Widths
    // ********************

    // Data word: operands, results, pc and immediates
    typedef logic [31:0] u32_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // ********************
    // Register file
    // ********************

    localparam int num_regs = 32;

    // Instruction size, used for the link value
    localparam u32_t pc_step = 32'd4;

    // ********************
    // ALU operations
    // ********************

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_slt  = 3'd5,    // signed compare
        op_lui  = 3'd6,    // immediate passes through
        op_link = 3'd7     // pc + pc_step
    } alu_op_t;

endpackage

//--- src/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic              clk,
    input  logic              rst_n,

    // Write port
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::u32_t     wdata,

    // Read ports
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    output cpu_pkg::u32_t     rdata1,
    output cpu_pkg::u32_t     rdata2
);

    cpu_pkg::u32_t regs [cpu_pkg::num_regs];

    // ********************
    // Write
    // ********************

    // Register 0 is never written and reads zero
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            for (int i = 0; i < cpu_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // ********************
    // Read
    // ********************

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- src/ex_stage.sv
`timescale 1ns/10ps

module ex_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              wb_rdy,

    // Issue side
    input  logic              issue_valid,
    input  cpu_pkg::alu_op_t  issue_op,
    input  cpu_pkg::reg_idx_t issue_rs1,
    input  cpu_pkg::reg_idx_t issue_rs2,
    input  cpu_pkg::reg_idx_t issue_rd,
    input  logic              issue_use_imm,
    input  logic              issue_wr_rd,
    input  cpu_pkg::u32_t     issue_imm,
    input  cpu_pkg::u32_t     issue_pc,
    output logic              issue_rdy,

    // Register file reads
    output cpu_pkg::reg_idx_t ra1,
    output cpu_pkg::reg_idx_t ra2,
    input  cpu_pkg::u32_t     rdata1,
    input  cpu_pkg::u32_t     rdata2,

    // Writeback bypass
    input  logic              reg_we,
    input  cpu_pkg::reg_idx_t reg_idx,
    input  cpu_pkg::u32_t     reg_data,

    // To writeback
    output logic              ex_valid,
    output cpu_pkg::u32_t     ex_pc,
    output cpu_pkg::reg_idx_t ex_rd,
    output logic              ex_wr_rd,
    output cpu_pkg::u32_t     ex_result
);

    logic              valid_r;
    cpu_pkg::alu_op_t  op_r;
    cpu_pkg::reg_idx_t rs1_r;
    cpu_pkg::reg_idx_t rs2_r;
    cpu_pkg::reg_idx_t rd_r;
    logic              use_imm_r;
    logic              wr_rd_r;
    cpu_pkg::u32_t     imm_r;
    cpu_pkg::u32_t     pc_r;

    cpu_pkg::u32_t     src1;
    cpu_pkg::u32_t     src2;
    cpu_pkg::u32_t     opnd2;

    // ********************
    // Input register
    // ********************

    // Accept on flush, when empty, or when writeback takes ours
    assign issue_rdy = flush | ~valid_r | wb_rdy;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            valid_r <= 1'b0;
        end else if (issue_rdy) begin
            valid_r <= issue_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_rdy) begin
            op_r      <= issue_op;
            rs1_r     <= issue_rs1;
            rs2_r     <= issue_rs2;
            rd_r      <= issue_rd;
            use_imm_r <= issue_use_imm;
            wr_rd_r   <= issue_wr_rd;
            imm_r     <= issue_imm;
            pc_r      <= issue_pc;
        end
    end

    // ********************
    // Operands
    // ********************

    assign ra1 = rs1_r;
    assign ra2 = rs2_r;

    // Firing writeback has not reached the file yet
    assign src1 = (reg_we && reg_idx == rs1_r && rs1_r != '0) ? reg_data : rdata1;
    assign src2 = (reg_we && reg_idx == rs2_r && rs2_r != '0) ? reg_data : rdata2;

    assign opnd2 = use_imm_r ? imm_r : src2;

    // ********************
    // ALU
    // ********************

    always_comb begin
        case (op_r)
            cpu_pkg::op_add:  ex_result = src1 + opnd2;
            cpu_pkg::op_sub:  ex_result = src1 - opnd2;
            cpu_pkg::op_and:  ex_result = src1 & opnd2;
            cpu_pkg::op_or:   ex_result = src1 | opnd2;
            cpu_pkg::op_xor:  ex_result = src1 ^ opnd2;
            cpu_pkg::op_slt:  ex_result = cpu_pkg::u32_t'($signed(src1) < $signed(opnd2));
            cpu_pkg::op_lui:  ex_result = imm_r;
            cpu_pkg::op_link: ex_result = pc_r + cpu_pkg::pc_step;
            default:          ex_result = '0;
        endcase
    end

    assign ex_valid = valid_r;
    assign ex_pc    = pc_r;
    assign ex_rd    = rd_r;
    assign ex_wr_rd = wr_rd_r;

endmodule

//--- src/writeback.sv
`timescale 1ns/10ps

module writeback (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              commit_rdy,

    // From execute
    input  logic              ex_valid,
    input  cpu_pkg::u32_t     ex_pc,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  logic              ex_wr_rd,
    input  cpu_pkg::u32_t     ex_result,
    output logic              wb_rdy,

    // To register file and bypass
    output logic              reg_we,
    output cpu_pkg::reg_idx_t reg_idx,
    output cpu_pkg::u32_t     reg_data,

    // Commit record
    output logic              cmt_valid,
    output logic              cmt_wen,
    output cpu_pkg::u32_t     cmt_pc,
    output cpu_pkg::reg_idx_t cmt_wdest,
    output cpu_pkg::u32_t     cmt_wdata
);

    logic              valid_r;
    cpu_pkg::u32_t     pc_r;
    cpu_pkg::reg_idx_t rd_r;
    logic              wr_rd_r;
    cpu_pkg::u32_t     result_r;
    logic              fire;

    // ********************
    // Stage register
    // ********************

    assign wb_rdy = flush | ~valid_r | commit_rdy;
    assign fire   = valid_r & ~flush & commit_rdy;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            valid_r <= 1'b0;
        end else if (wb_rdy) begin
            valid_r <= ex_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_rdy) begin
            pc_r     <= ex_pc;
            rd_r     <= ex_rd;
            wr_rd_r  <= ex_wr_rd;
            result_r <= ex_result;
        end
    end

    // Write only once, on the firing cycle
    assign reg_we   = fire & wr_rd_r & (rd_r != '0);
    assign reg_idx  = rd_r;
    assign reg_data = result_r;

    // ********************
    // Commit record
    // ********************

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            cmt_valid <= 1'b0;
            cmt_wen   <= 1'b0;
        end else begin
            cmt_valid <= fire;
            cmt_wen   <= reg_we;
        end
    end

    // Payload only moves with a retiring instruction
    always_ff @(posedge clk) begin
        if (fire) begin
            cmt_pc    <= pc_r;
            cmt_wdest <= rd_r;
            cmt_wdata <= result_r;
        end
    end

endmodule

//--- src/cpu_backend.sv
`timescale 1ns/10ps

module cpu_backend (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              commit_rdy,

    input  logic              issue_valid,
    input  cpu_pkg::alu_op_t  issue_op,
    input  cpu_pkg::reg_idx_t issue_rs1,
    input  cpu_pkg::reg_idx_t issue_rs2,
    input  cpu_pkg::reg_idx_t issue_rd,
    input  logic              issue_use_imm,
    input  logic              issue_wr_rd,
    input  cpu_pkg::u32_t     issue_imm,
    input  cpu_pkg::u32_t     issue_pc,
    output logic              issue_rdy,

    output logic              cmt_valid,
    output logic              cmt_wen,
    output cpu_pkg::u32_t     cmt_pc,
    output cpu_pkg::reg_idx_t cmt_wdest,
    output cpu_pkg::u32_t     cmt_wdata
);

    // Execute to writeback
    logic              ex_valid;
    cpu_pkg::u32_t     ex_pc;
    cpu_pkg::reg_idx_t ex_rd;
    logic              ex_wr_rd;
    cpu_pkg::u32_t     ex_result;
    logic              wb_rdy;

    // Register file reads
    cpu_pkg::reg_idx_t ra1;
    cpu_pkg::reg_idx_t ra2;
    cpu_pkg::u32_t     rdata1;
    cpu_pkg::u32_t     rdata2;

    // Writeback port, also the bypass
    logic              reg_we;
    cpu_pkg::reg_idx_t reg_idx;
    cpu_pkg::u32_t     reg_data;

    ex_stage u_ex_stage (
        .clk           (clk          ),
        .rst_n         (rst_n        ),
        .flush         (flush        ),
        .wb_rdy        (wb_rdy       ),
        .issue_valid   (issue_valid  ),
        .issue_op      (issue_op     ),
        .issue_rs1     (issue_rs1    ),
        .issue_rs2     (issue_rs2    ),
        .issue_rd      (issue_rd     ),
        .issue_use_imm (issue_use_imm),
        .issue_wr_rd   (issue_wr_rd  ),
        .issue_imm     (issue_imm    ),
        .issue_pc      (issue_pc     ),
        .issue_rdy     (issue_rdy    ),
        .ra1           (ra1          ),
        .ra2           (ra2          ),
        .rdata1        (rdata1       ),
        .rdata2        (rdata2       ),
        .reg_we        (reg_we       ),
        .reg_idx       (reg_idx      ),
        .reg_data      (reg_data     ),
        .ex_valid      (ex_valid     ),
        .ex_pc         (ex_pc        ),
        .ex_rd         (ex_rd        ),
        .ex_wr_rd      (ex_wr_rd     ),
        .ex_result     (ex_result    )
    );

    writeback u_writeback (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .flush      (flush     ),
        .commit_rdy (commit_rdy),
        .ex_valid   (ex_valid  ),
        .ex_pc      (ex_pc     ),
        .ex_rd      (ex_rd     ),
        .ex_wr_rd   (ex_wr_rd  ),
        .ex_result  (ex_result ),
        .wb_rdy     (wb_rdy    ),
        .reg_we     (reg_we    ),
        .reg_idx    (reg_idx   ),
        .reg_data   (reg_data  ),
        .cmt_valid  (cmt_valid ),
        .cmt_wen    (cmt_wen   ),
        .cmt_pc     (cmt_pc    ),
        .cmt_wdest  (cmt_wdest ),
        .cmt_wdata  (cmt_wdata )
    );

    regfile u_regfile (
        .clk    (clk     ),
        .rst_n  (rst_n   ),
        .we     (reg_we  ),
        .waddr  (reg_idx ),
        .wdata  (reg_data),
        .raddr1 (ra1     ),
        .raddr2 (ra2     ),
        .rdata1 (rdata1  ),
        .rdata2 (rdata2  )
    );

endmodule

//--- tests/tb_cpu_backend.sv
`timescale 1ns/10ps

module tb_cpu_backend;

    localparam logic [31:0] seed = 32'hc481;
    localparam int timeout_cycles = 200;
    localparam int instrs_per_phase = 150;

    typedef struct packed {
        cpu_pkg::u32_t     pc;
        logic              wen;
        cpu_pkg::reg_idx_t wdest;
        cpu_pkg::u32_t     wdata;
    } commit_rec_t;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              commit_rdy;
    logic              issue_valid;
    cpu_pkg::alu_op_t  issue_op;
    cpu_pkg::reg_idx_t issue_rs1;
    cpu_pkg::reg_idx_t issue_rs2;
    cpu_pkg::reg_idx_t issue_rd;
    logic              issue_use_imm;
    logic              issue_wr_rd;
    cpu_pkg::u32_t     issue_imm;
    cpu_pkg::u32_t     issue_pc;
    logic              issue_rdy;
    logic              cmt_valid;
    logic              cmt_wen;
    cpu_pkg::u32_t     cmt_pc;
    cpu_pkg::reg_idx_t cmt_wdest;
    cpu_pkg::u32_t     cmt_wdata;

    // Speculative state in issue order, and the retired state
    cpu_pkg::u32_t     spec_regs [cpu_pkg::num_regs];
    cpu_pkg::u32_t     committed_regs [cpu_pkg::num_regs];
    commit_rec_t       expect_q [$];
    commit_rec_t       new_rec;
    commit_rec_t       done_rec;
    cpu_pkg::u32_t     opnd_a;
    cpu_pkg::u32_t     opnd_b;
    int                in_stages;
    logic              rdy_expected;
    cpu_pkg::u32_t     pc_next;
    string             test_name;
    int                drain_wait;

    cpu_backend u_cpu_backend (.*);

    always #2 clk = ~clk;

    // ********************
    // Reporting
    // ********************

    task automatic report_mismatch(input string field, input cpu_pkg::u32_t exp,
                                   input cpu_pkg::u32_t act);
        $display("CHECK FAILED %s %s: expected %h actual %h", test_name, field, exp, act);
        $display("Checks failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("Error in %s: %s", test_name, why);
        $display("Checks failed");
        $fatal(1, "run aborted");
    endtask

    // ********************
    // Reference model
    // ********************

    function automatic cpu_pkg::u32_t alu_ref(input cpu_pkg::alu_op_t op,
                                              input cpu_pkg::u32_t a, input cpu_pkg::u32_t b,
                                              input cpu_pkg::u32_t imm,
                                              input cpu_pkg::u32_t pc);
        case (op)
            cpu_pkg::op_add:  return a + b;
            cpu_pkg::op_sub:  return a - b;
            cpu_pkg::op_and:  return a & b;
            cpu_pkg::op_or:   return a | b;
            cpu_pkg::op_xor:  return a ^ b;
            cpu_pkg::op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::op_lui:  return imm;
            default:          return pc + 32'd4;
        endcase
    endfunction

    // Edge-by-edge tracking of issue, commit and flush
    always @(posedge clk) begin
        if (rst_n) begin
            if (cmt_valid && expect_q.size() == 0) begin
                abort_run("commit seen with no instruction in flight");
            end
            in_stages = expect_q.size() - (cmt_valid ? 1 : 0);
            rdy_expected = flush | commit_rdy | (in_stages < 2);
            assert (issue_rdy == rdy_expected) else
                report_mismatch("issue_rdy", 32'(rdy_expected), 32'(issue_rdy));
            if (cmt_valid) begin
                done_rec = expect_q.pop_front();
                assert (cmt_pc == done_rec.pc) else
                    report_mismatch("cmt_pc", done_rec.pc, cmt_pc);
                assert (cmt_wen == done_rec.wen) else
                    report_mismatch("cmt_wen", 32'(done_rec.wen), 32'(cmt_wen));
                assert (cmt_wdest == done_rec.wdest) else
                    report_mismatch("cmt_wdest", 32'(done_rec.wdest), 32'(cmt_wdest));
                assert (cmt_wdata == done_rec.wdata) else
                    report_mismatch("cmt_wdata", done_rec.wdata, cmt_wdata);
                if (done_rec.wen) begin
                    committed_regs[done_rec.wdest] = done_rec.wdata;
                end
            end
            if (flush) begin
                // Drop what is still in the stages, replay from retired state
                expect_q.delete();
                spec_regs = committed_regs;
            end else if (issue_valid && issue_rdy) begin
                opnd_a = spec_regs[issue_rs1];
                opnd_b = issue_use_imm ? issue_imm : spec_regs[issue_rs2];
                new_rec.pc    = issue_pc;
                new_rec.wdest = issue_rd;
                new_rec.wen   = issue_wr_rd && (issue_rd != 5'd0);
                new_rec.wdata = alu_ref(issue_op, opnd_a, opnd_b, issue_imm, issue_pc);
                expect_q.push_back(new_rec);
                if (new_rec.wen) begin
                    spec_regs[issue_rd] = new_rec.wdata;
                end
            end
        end
    end

    // ********************
    // Stimulus
    // ********************

    task automatic drive_controls(input int rdy_pct, input int flush_pct);
        commit_rdy = ($urandom_range(99) < rdy_pct);
        flush      = ($urandom_range(99) < flush_pct);
    endtask

    task automatic send_instr(input int valid_pct, input int rdy_pct, input int flush_pct);
        int         gap;
        int         waited;
        logic [2:0] op_bits;
        if ($urandom_range(99) < valid_pct) begin
            gap = 0;
        end else begin
            gap = 1 + $urandom_range(3);
        end
        repeat (gap) begin
            @(negedge clk);
            issue_valid = 1'b0;
            drive_controls(rdy_pct, flush_pct);
        end
        @(negedge clk);
        op_bits       = 3'($urandom_range(7));
        issue_op      = cpu_pkg::alu_op_t'(op_bits);
        // Few registers, so dependencies are frequent
        issue_rs1     = 5'($urandom_range(7));
        issue_rs2     = 5'($urandom_range(7));
        issue_rd      = 5'($urandom_range(7));
        issue_use_imm = 1'($urandom_range(1));
        issue_wr_rd   = ($urandom_range(9) != 0);
        issue_imm     = $urandom();
        issue_pc      = pc_next;
        issue_valid   = 1'b1;
        drive_controls(rdy_pct, flush_pct);
        waited = 0;
        @(posedge clk);
        while (!issue_rdy) begin
            waited++;
            if (waited > timeout_cycles) begin
                abort_run("timeout waiting for issue_rdy");
            end else begin
                @(negedge clk);
                drive_controls(rdy_pct, flush_pct);
                @(posedge clk);
            end
        end
        pc_next = pc_next + 32'd4;
    endtask

    initial begin
        void'($urandom(seed));
        clk           = 1'b0;
        rst_n         = 1'b0;
        flush         = 1'b0;
        commit_rdy    = 1'b0;
        issue_valid   = 1'b0;
        issue_op      = cpu_pkg::op_add;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rd      = '0;
        issue_use_imm = 1'b0;
        issue_wr_rd   = 1'b0;
        issue_imm     = '0;
        issue_pc      = '0;
        pc_next       = 32'h0000_1000;
        for (int i = 0; i < cpu_pkg::num_regs; i++) begin
            spec_regs[i]      = '0;
            committed_regs[i] = '0;
        end
        test_name = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (cmt_valid == 1'b0) else report_mismatch("cmt_valid", 32'd0, 32'(cmt_valid));
        assert (issue_rdy == 1'b1) else report_mismatch("issue_rdy", 32'd1, 32'(issue_rdy));

        test_name = "back_to_back";
        repeat (instrs_per_phase) send_instr(100, 100, 0);
        test_name = "random_gaps";
        repeat (instrs_per_phase) send_instr(70, 70, 0);
        test_name = "back_pressure";
        repeat (instrs_per_phase) send_instr(90, 40, 0);
        test_name = "flush";
        repeat (instrs_per_phase) send_instr(80, 70, 8);

        // Let everything in flight retire
        test_name = "drain";
        @(negedge clk);
        issue_valid = 1'b0;
        commit_rdy  = 1'b1;
        flush       = 1'b0;
        drain_wait  = 0;
        while (expect_q.size() != 0) begin
            @(negedge clk);
            drain_wait++;
            if (drain_wait > timeout_cycles) begin
                abort_run("timeout waiting for the pipeline to drain");
            end
        end
        repeat (4) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- project.f
src/cpu_pkg.sv
src/regfile.sv
src/ex_stage.sv
src/writeback.sv
src/cpu_backend.sv
tests/tb_cpu_backend.sv

//--- Makefile
# Verilator build and run of the backend testbench

BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_cpu_backend -Mdir $(BUILD_DIR) -f project.f
	./$(BUILD_DIR)/Vtb_cpu_backend

clean:
	rm -rf $(BUILD_DIR)
